// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_axi_rd_xbar
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := === FAIL ===

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# A crashed simulation also counts as a failure
run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: project.f
src/axi_rd_pkg.sv
src/ar_arbiter.sv
src/ar_router.sv
src/r_router.sv
src/default_slave.sv
src/axi_rd_xbar.sv
tests/tb_slave_model.sv
tests/tb_axi_rd_xbar.sv

// File: src/ar_arbiter.sv
// AR arbiter
// Round-robin choice between the two masters' read requests.
// A grant stays on its master until the AR handshake completes

`timescale 1ns/1ps

module ar_arbiter (
    input  logic                 ACLK,
    input  logic                 ARESETn,
    input  axi_rd_pkg::mst_sel_t req,
    input  logic                 handshake,
    output axi_rd_pkg::mst_sel_t grant
);

    // Priority pointer, 0 favours master 0
    logic                 prio_q;
    // Held grant, zero when no grant is pending
    axi_rd_pkg::mst_sel_t lock_q;
    axi_rd_pkg::mst_sel_t rr_grant;

    // Fresh round-robin pick
    always_comb begin
        rr_grant = '0;
        if (!prio_q) begin
            if (req[0]) begin
                rr_grant = 2'b01;
            end else if (req[1]) begin
                rr_grant = 2'b10;
            end
        end else begin
            if (req[1]) begin
                rr_grant = 2'b10;
            end else if (req[0]) begin
                rr_grant = 2'b01;
            end
        end
    end

    // Pending grant wins over any new pick
    assign grant = (lock_q != '0) ? lock_q : rr_grant;

    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            prio_q <= 1'b0;
            lock_q <= '0;
        end else if (handshake) begin
            // Hand priority to the other master
            prio_q <= grant[0];
            lock_q <= '0;
        end else begin
            lock_q <= grant;
        end
    end

    // Grant is one-hot or idle and never names an idle requester
    a_grant_legal: assert property (@(posedge ACLK) disable iff (!ARESETn)
        $onehot0(grant) && ((grant & ~req) == '0));

endmodule

// File: src/ar_router.sv
// AR router
// Muxes the granted master's read request, tags its ID with the
// master index and decodes the address to slave 0, slave 1 or the
// default slave. Steers valid out and ready back

`timescale 1ns/1ps

module ar_router (
    input  axi_rd_pkg::mst_sel_t grant,
    input  axi_rd_pkg::ar_req_t  m0_ar,
    input  logic                 m0_ar_valid,
    input  axi_rd_pkg::ar_req_t  m1_ar,
    input  logic                 m1_ar_valid,
    output logic                 m0_ar_ready,
    output logic                 m1_ar_ready,
    output axi_rd_pkg::ar_slv_t  s_ar,
    output logic                 s0_ar_valid,
    output logic                 s1_ar_valid,
    output logic                 sd_ar_valid,
    input  logic                 s0_ar_ready,
    input  logic                 s1_ar_ready,
    input  logic                 sd_ar_ready,
    output logic                 handshake
);

    axi_rd_pkg::ar_req_t sel_ar;
    logic                sel_valid;
    logic                hit_s0;
    logic                hit_s1;
    logic                sel_ready;

    // ============================================================
    // Request mux and ID tag
    // ============================================================
    always_comb begin
        sel_ar    = '0;
        sel_valid = 1'b0;
        s_ar      = '0;
        if (grant[0]) begin
            sel_ar      = m0_ar;
            sel_valid   = m0_ar_valid;
            s_ar.id.mst = axi_rd_pkg::M0_IDX;
        end else if (grant[1]) begin
            sel_ar      = m1_ar;
            sel_valid   = m1_ar_valid;
            s_ar.id.mst = axi_rd_pkg::M1_IDX;
        end
        // Broadcast payload, only valid is steered
        s_ar.id.id = sel_ar.id;
        s_ar.addr  = sel_ar.addr;
        s_ar.len   = sel_ar.len;
        s_ar.size  = sel_ar.size;
        s_ar.burst = sel_ar.burst;
    end

    // ============================================================
    // Decode and valid steering
    // ============================================================
    assign hit_s0 = (sel_ar.addr & axi_rd_pkg::S0_MASK) == axi_rd_pkg::S0_BASE;
    assign hit_s1 = (sel_ar.addr & axi_rd_pkg::S1_MASK) == axi_rd_pkg::S1_BASE;

    always_comb begin
        s0_ar_valid = sel_valid && hit_s0;
        s1_ar_valid = sel_valid && hit_s1;
        // Anything outside the map goes to the default slave
        sd_ar_valid = sel_valid && !hit_s0 && !hit_s1;
        // Two regions of the map that overlap would raise two valids
        a_one_target: assert ($onehot0({s0_ar_valid, s1_ar_valid, sd_ar_valid}));
    end

    // Ready from the decoded slave only
    assign sel_ready = hit_s0 ? s0_ar_ready :
                       hit_s1 ? s1_ar_ready : sd_ar_ready;

    assign m0_ar_ready = grant[0] && sel_ready;
    assign m1_ar_ready = grant[1] && sel_ready;

    // Pulse to the arbiter
    assign handshake = sel_valid && sel_ready;

endmodule

// File: src/axi_rd_pkg.sv
// AXI read crossbar shared definitions
// Bus widths, the slave address map, response codes and the
// packed channel structs used on the master and slave sides

package axi_rd_pkg;

    // ============================================================
    // Widths
    // ============================================================
    localparam int ID_BITS    = 4;
    // Master index prepended to the ID on the slave side
    localparam int MST_BITS   = 1;
    localparam int ADDR_BITS  = 32;
    localparam int DATA_BITS  = 32;
    // Burst carries len + 1 beats
    localparam int LEN_BITS   = 4;
    localparam int SIZE_BITS  = 3;
    localparam int BURST_BITS = 2;
    localparam int RESP_BITS  = 2;

    // ============================================================
    // Address map
    // ============================================================
    // A region hits when (addr & MASK) == BASE
    localparam logic [ADDR_BITS-1:0] S0_BASE = 32'h0000_0000;
    localparam logic [ADDR_BITS-1:0] S0_MASK = 32'hFFFF_0000;
    localparam logic [ADDR_BITS-1:0] S1_BASE = 32'h0001_0000;
    localparam logic [ADDR_BITS-1:0] S1_MASK = 32'hFFFF_0000;

    // Response codes
    localparam logic [RESP_BITS-1:0] RESP_OKAY   = 2'b00;
    localparam logic [RESP_BITS-1:0] RESP_DECERR = 2'b11;

    // Master index values carried in the slave-side ID
    localparam logic [MST_BITS-1:0] M0_IDX = 1'b0;
    localparam logic [MST_BITS-1:0] M1_IDX = 1'b1;

    // ============================================================
    // Channel types
    // ============================================================
    // One-hot grant, bit 0 is master 0
    typedef logic [1:0] mst_sel_t;

    // Slave-side ID: owning master in the top bits
    typedef struct packed {
        logic [MST_BITS-1:0] mst;
        logic [ID_BITS-1:0]  id;
    } slv_id_t;

    // AR payload seen by a master
    typedef struct packed {
        logic [ID_BITS-1:0]    id;
        logic [ADDR_BITS-1:0]  addr;
        logic [LEN_BITS-1:0]   len;
        logic [SIZE_BITS-1:0]  size;
        logic [BURST_BITS-1:0] burst;
    } ar_req_t;

    // AR payload seen by a slave
    typedef struct packed {
        slv_id_t               id;
        logic [ADDR_BITS-1:0]  addr;
        logic [LEN_BITS-1:0]   len;
        logic [SIZE_BITS-1:0]  size;
        logic [BURST_BITS-1:0] burst;
    } ar_slv_t;

    // R beat from a slave
    typedef struct packed {
        slv_id_t               id;
        logic [DATA_BITS-1:0]  data;
        logic [RESP_BITS-1:0]  resp;
        logic                  last;
    } r_slv_t;

    // R beat delivered to a master
    typedef struct packed {
        logic [ID_BITS-1:0]    id;
        logic [DATA_BITS-1:0]  data;
        logic [RESP_BITS-1:0]  resp;
        logic                  last;
    } r_mst_t;

endpackage

// File: src/axi_rd_xbar.sv
// AXI read crossbar, two masters to two slaves
// Master 0 fetches instructions, master 1 reads data. Unmapped
// reads are answered by an internal default slave

`timescale 1ns/1ps

module axi_rd_xbar (
    input  logic                 ACLK,
    input  logic                 ARESETn,

    // ============================================================
    // Master ports
    // ============================================================
    input  axi_rd_pkg::ar_req_t  m0_ar,
    input  logic                 m0_ar_valid,
    output logic                 m0_ar_ready,
    output axi_rd_pkg::r_mst_t   m0_r,
    output logic                 m0_r_valid,
    input  logic                 m0_r_ready,

    input  axi_rd_pkg::ar_req_t  m1_ar,
    input  logic                 m1_ar_valid,
    output logic                 m1_ar_ready,
    output axi_rd_pkg::r_mst_t   m1_r,
    output logic                 m1_r_valid,
    input  logic                 m1_r_ready,

    // ============================================================
    // Slave ports
    // ============================================================
    output axi_rd_pkg::ar_slv_t  s0_ar,
    output logic                 s0_ar_valid,
    input  logic                 s0_ar_ready,
    input  axi_rd_pkg::r_slv_t   s0_r,
    input  logic                 s0_r_valid,
    output logic                 s0_r_ready,

    output axi_rd_pkg::ar_slv_t  s1_ar,
    output logic                 s1_ar_valid,
    input  logic                 s1_ar_ready,
    input  axi_rd_pkg::r_slv_t   s1_r,
    input  logic                 s1_r_valid,
    output logic                 s1_r_ready
);

    axi_rd_pkg::mst_sel_t ar_grant;
    logic                 ar_handshake;
    // Granted request, seen by every slave
    axi_rd_pkg::ar_slv_t  ar_bcast;
    // Default slave channels
    logic                 sd_ar_valid;
    logic                 sd_ar_ready;
    axi_rd_pkg::r_slv_t   sd_r;
    logic                 sd_r_valid;
    logic                 sd_r_ready;

    assign s0_ar = ar_bcast;
    assign s1_ar = ar_bcast;

    ar_arbiter u_ar_arbiter (
        .ACLK      (ACLK),
        .ARESETn   (ARESETn),
        .req       ({m1_ar_valid, m0_ar_valid}),
        .handshake (ar_handshake),
        .grant     (ar_grant)
    );

    ar_router u_ar_router (
        .grant       (ar_grant),
        .m0_ar       (m0_ar),
        .m0_ar_valid (m0_ar_valid),
        .m1_ar       (m1_ar),
        .m1_ar_valid (m1_ar_valid),
        .m0_ar_ready (m0_ar_ready),
        .m1_ar_ready (m1_ar_ready),
        .s_ar        (ar_bcast),
        .s0_ar_valid (s0_ar_valid),
        .s1_ar_valid (s1_ar_valid),
        .sd_ar_valid (sd_ar_valid),
        .s0_ar_ready (s0_ar_ready),
        .s1_ar_ready (s1_ar_ready),
        .sd_ar_ready (sd_ar_ready),
        .handshake   (ar_handshake)
    );

    r_router u_r_router (
        .s0_r       (s0_r),
        .s0_r_valid (s0_r_valid),
        .s1_r       (s1_r),
        .s1_r_valid (s1_r_valid),
        .sd_r       (sd_r),
        .sd_r_valid (sd_r_valid),
        .s0_r_ready (s0_r_ready),
        .s1_r_ready (s1_r_ready),
        .sd_r_ready (sd_r_ready),
        .m0_r       (m0_r),
        .m0_r_valid (m0_r_valid),
        .m1_r       (m1_r),
        .m1_r_valid (m1_r_valid),
        .m0_r_ready (m0_r_ready),
        .m1_r_ready (m1_r_ready)
    );

    // Catches every unmapped read
    default_slave u_default_slave (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .ar       (ar_bcast),
        .ar_valid (sd_ar_valid),
        .ar_ready (sd_ar_ready),
        .r        (sd_r),
        .r_valid  (sd_r_valid),
        .r_ready  (sd_r_ready)
    );

endmodule

// File: src/default_slave.sv
// Default slave
// Accepts reads to unmapped addresses and returns the requested
// number of beats with zero data and a decode-error response

`timescale 1ns/1ps

module default_slave (
    input  logic                ACLK,
    input  logic                ARESETn,
    input  axi_rd_pkg::ar_slv_t ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output axi_rd_pkg::r_slv_t  r,
    output logic                r_valid,
    input  logic                r_ready
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t                          state_q;
    logic [axi_rd_pkg::LEN_BITS-1:0] cnt_q;
    logic [axi_rd_pkg::LEN_BITS-1:0] len_q;
    axi_rd_pkg::slv_id_t             id_q;
    logic                            ar_fire;
    logic                            r_fire;
    logic                            last_beat;

    // ============================================================
    // Handshakes
    // ============================================================
    assign ar_ready  = (state_q == ST_IDLE);
    assign ar_fire   = ar_valid && ar_ready;
    assign r_valid   = (state_q == ST_BUSY);
    assign r_fire    = r_valid && r_ready;
    assign last_beat = (cnt_q == len_q);

    // Beat payload, only last changes within a burst
    always_comb begin
        r      = '0;
        r.id   = id_q;
        r.resp = axi_rd_pkg::RESP_DECERR;
        r.last = last_beat;
    end

    // ============================================================
    // FSM and beat counter
    // ============================================================
    always_ff @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            state_q <= ST_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (ar_fire) begin
                        state_q <= ST_BUSY;
                        cnt_q   <= '0;
                    end
                end
                ST_BUSY: begin
                    if (r_fire) begin
                        // Last beat out, ready for next AR
                        if (last_beat) begin
                            state_q <= ST_IDLE;
                        end else begin
                            cnt_q <= cnt_q + 1'b1;
                        end
                    end
                end
                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Request fields kept for the burst
    always_ff @(posedge ACLK) begin
        if (ar_fire) begin
            id_q  <= ar.id;
            len_q <= ar.len;
        end
    end

    // Stalled beat holds until taken
    a_r_hold: assert property (@(posedge ACLK) disable iff (!ARESETn)
        (r_valid && !r_ready) |=> (r_valid && $stable(r)));

endmodule

// File: src/r_router.sv
// R router
// Picks one slave's read beat by fixed priority S0, S1, default,
// strips the master index from its ID and hands it to that master

`timescale 1ns/1ps

module r_router (
    input  axi_rd_pkg::r_slv_t s0_r,
    input  logic               s0_r_valid,
    input  axi_rd_pkg::r_slv_t s1_r,
    input  logic               s1_r_valid,
    input  axi_rd_pkg::r_slv_t sd_r,
    input  logic               sd_r_valid,
    output logic               s0_r_ready,
    output logic               s1_r_ready,
    output logic               sd_r_ready,
    output axi_rd_pkg::r_mst_t m0_r,
    output logic               m0_r_valid,
    output axi_rd_pkg::r_mst_t m1_r,
    output logic               m1_r_valid,
    input  logic               m0_r_ready,
    input  logic               m1_r_ready
);

    axi_rd_pkg::r_slv_t sel_r;
    axi_rd_pkg::r_mst_t beat;
    logic               sel_valid;
    logic               to_m1;
    logic               mst_ready;

    // Fixed priority slave select
    always_comb begin
        sel_r     = '0;
        sel_valid = 1'b0;
        if (s0_r_valid) begin
            sel_r     = s0_r;
            sel_valid = 1'b1;
        end else if (s1_r_valid) begin
            sel_r     = s1_r;
            sel_valid = 1'b1;
        end else if (sd_r_valid) begin
            sel_r     = sd_r;
            sel_valid = 1'b1;
        end
    end

    // Master index decides the destination
    assign to_m1 = (sel_r.id.mst == axi_rd_pkg::M1_IDX);

    // Drop the tag, keep the master's own ID
    assign beat = '{id: sel_r.id.id, data: sel_r.data, resp: sel_r.resp, last: sel_r.last};

    assign m0_r = beat;
    assign m1_r = beat;

    // Each master matches its own index value
    always_comb begin
        m0_r_valid = sel_valid && (sel_r.id.mst == axi_rd_pkg::M0_IDX);
        m1_r_valid = sel_valid && (sel_r.id.mst == axi_rd_pkg::M1_IDX);
        a_one_master: assert (!(m0_r_valid && m1_r_valid));
    end

    // ============================================================
    // Ready back to the selected slave only
    // ============================================================
    assign mst_ready  = to_m1 ? m1_r_ready : m0_r_ready;
    assign s0_r_ready = s0_r_valid && mst_ready;
    assign s1_r_ready = !s0_r_valid && s1_r_valid && mst_ready;
    assign sd_r_ready = !s0_r_valid && !s1_r_valid && sd_r_valid && mst_ready;

endmodule

// File: tests/tb_axi_rd_xbar.sv
// Testbench for the AXI read crossbar
// Two random masters issue reads to slave 0, slave 1 and unmapped
// space; a model predicts every beat and checks order, data and last

`timescale 1ns/1ps

module tb_axi_rd_xbar;

    localparam int          NUM_READS  = 150;
    // Both masters x reads x 8 beats x 8 cycles worst case, plus margin
    localparam int          MAX_CYCLES = 2 * NUM_READS * 8 * 8 + 1000;
    localparam logic [31:0] RND_SEED   = 32'd16046;
    localparam logic [31:0] S0_KEY     = 32'h5A5A_0F0F;
    localparam logic [31:0] S1_KEY     = 32'hC3C3_1234;
    localparam logic [1:0]  OKAY       = 2'b00;
    localparam logic [1:0]  DECERR     = 2'b11;
    // Word beats, incrementing burst
    localparam logic [2:0]  AR_SIZE    = 3'd2;
    localparam logic [1:0]  AR_BURST   = 2'b01;
    // Target of a read
    localparam logic [1:0]  TGT_S0     = 2'd0;
    localparam logic [1:0]  TGT_S1     = 2'd1;
    localparam logic [1:0]  TGT_DEF    = 2'd2;

    logic ACLK;
    logic ARESETn = 1'b0;

    // Master side, index is the master number
    axi_rd_pkg::ar_req_t [1:0] mst_ar       = '0;
    logic [1:0]                mst_ar_valid = '0;
    logic [1:0]                mst_ar_ready;
    axi_rd_pkg::r_mst_t  [1:0] mst_r;
    logic [1:0]                mst_r_valid;
    logic [1:0]                mst_r_ready  = '0;

    // Slave side
    axi_rd_pkg::ar_slv_t s0_ar;
    axi_rd_pkg::ar_slv_t s1_ar;
    logic                s0_ar_valid;
    logic                s1_ar_valid;
    logic                s0_ar_ready;
    logic                s1_ar_ready;
    axi_rd_pkg::r_slv_t  s0_r;
    axi_rd_pkg::r_slv_t  s1_r;
    logic                s0_r_valid;
    logic                s1_r_valid;
    logic                s0_r_ready;
    logic                s1_r_ready;

    // ============================================================
    // Model state, one outstanding read per master
    // ============================================================
    logic [1:0]  outstanding = '0;
    logic [31:0] exp_addr [2];
    logic [3:0]  exp_len  [2];
    logic [3:0]  exp_id   [2];
    logic [1:0]  exp_tgt  [2];
    logic [3:0]  beat_cnt [2];
    int          issued    [2];
    int          completed [2];
    logic [31:0] rnd = RND_SEED;
    int          cycles = 0;
    logic        all_done;
    int          err_id = 0;
    int          err_data = 0;
    int          err_resp = 0;
    int          err_last = 0;
    int          err_stray = 0;
    int          err_ar = 0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Compare one received beat against the slave rules
    task automatic check_beat(input int m, input axi_rd_pkg::r_mst_t got);
        logic [31:0] exp_data;
        logic [1:0]  exp_resp;
        logic        exp_last;
        exp_last = (beat_cnt[m] == exp_len[m]);
        if (exp_tgt[m] == TGT_DEF) begin
            exp_data = 32'h0;
            exp_resp = DECERR;
        end else begin
            exp_data = (exp_addr[m] + {26'd0, beat_cnt[m], 2'b00}) ^
                       ((exp_tgt[m] == TGT_S0) ? S0_KEY : S1_KEY);
            exp_resp = OKAY;
        end
        a_id: assert (got.id == exp_id[m]) else begin
            err_id++;
            $display("ERR %0t m%0d id got %h exp %h", $time, m, got.id, exp_id[m]);
        end
        a_data: assert (got.data == exp_data) else begin
            err_data++;
            $display("ERR %0t m%0d beat %0d data got %h exp %h",
                     $time, m, beat_cnt[m], got.data, exp_data);
        end
        a_resp: assert (got.resp == exp_resp) else begin
            err_resp++;
            $display("ERR %0t m%0d resp got %0d exp %0d", $time, m, got.resp, exp_resp);
        end
        a_last: assert (got.last == exp_last) else begin
            err_last++;
            $display("ERR %0t m%0d beat %0d last got %b exp %b",
                     $time, m, beat_cnt[m], got.last, exp_last);
        end
    endtask

    // Compare one AR taken by a slave against the tagged master's read
    task automatic check_ar(input logic [1:0] tgt, input axi_rd_pkg::ar_slv_t got);
        int m;
        m = int'(got.id.mst);
        a_ar: assert (outstanding[m] && exp_tgt[m] == tgt && got.id.id == exp_id[m] &&
                      got.addr == exp_addr[m] && got.len == exp_len[m] &&
                      got.size == AR_SIZE && got.burst == AR_BURST) else begin
            err_ar++;
            $display("ERR %0t AR at target %0d m%0d id %h addr %h len %0d size %0d burst %0d",
                     $time, tgt, m, got.id.id, got.addr, got.len, got.size, got.burst);
        end
    endtask

    // ============================================================
    // DUT and slave models
    // ============================================================
    axi_rd_xbar dut0 (
        .ACLK        (ACLK),
        .ARESETn     (ARESETn),
        .m0_ar       (mst_ar[0]),
        .m0_ar_valid (mst_ar_valid[0]),
        .m0_ar_ready (mst_ar_ready[0]),
        .m0_r        (mst_r[0]),
        .m0_r_valid  (mst_r_valid[0]),
        .m0_r_ready  (mst_r_ready[0]),
        .m1_ar       (mst_ar[1]),
        .m1_ar_valid (mst_ar_valid[1]),
        .m1_ar_ready (mst_ar_ready[1]),
        .m1_r        (mst_r[1]),
        .m1_r_valid  (mst_r_valid[1]),
        .m1_r_ready  (mst_r_ready[1]),
        .s0_ar       (s0_ar),
        .s0_ar_valid (s0_ar_valid),
        .s0_ar_ready (s0_ar_ready),
        .s0_r        (s0_r),
        .s0_r_valid  (s0_r_valid),
        .s0_r_ready  (s0_r_ready),
        .s1_ar       (s1_ar),
        .s1_ar_valid (s1_ar_valid),
        .s1_ar_ready (s1_ar_ready),
        .s1_r        (s1_r),
        .s1_r_valid  (s1_r_valid),
        .s1_r_ready  (s1_r_ready)
    );

    tb_slave_model #(.KEY(S0_KEY), .SEED(RND_SEED + 32'd1)) slave0 (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .ar       (s0_ar),
        .ar_valid (s0_ar_valid),
        .ar_ready (s0_ar_ready),
        .r        (s0_r),
        .r_valid  (s0_r_valid),
        .r_ready  (s0_r_ready)
    );

    tb_slave_model #(.KEY(S1_KEY), .SEED(RND_SEED + 32'd2)) slave1 (
        .ACLK     (ACLK),
        .ARESETn  (ARESETn),
        .ar       (s1_ar),
        .ar_valid (s1_ar_valid),
        .ar_ready (s1_ar_ready),
        .r        (s1_r),
        .r_valid  (s1_r_valid),
        .r_ready  (s1_r_ready)
    );

    initial begin
        ACLK = 1'b0;
        forever #10 ACLK = ~ACLK;
    end

    always @(posedge ACLK) cycles <= cycles + 1;

    assign all_done = (completed[0] == NUM_READS) && (completed[1] == NUM_READS);

    // Requests seen by slave 0 and slave 1
    always @(posedge ACLK) begin
        if (ARESETn) begin
            if (s0_ar_valid && s0_ar_ready) begin
                check_ar(TGT_S0, s0_ar);
            end
            if (s1_ar_valid && s1_ar_ready) begin
                check_ar(TGT_S1, s1_ar);
            end
        end
    end

    // ============================================================
    // Random masters
    // ============================================================
    always @(posedge ACLK or negedge ARESETn) begin
        axi_rd_pkg::ar_req_t req;
        logic [31:0]         r1;
        logic [31:0]         r2;
        logic [1:0]          tgt;
        if (!ARESETn) begin
            mst_ar_valid <= '0;
            mst_r_ready  <= '0;
            outstanding  <= '0;
            for (int m = 0; m < 2; m++) begin
                issued[m]    <= 0;
                completed[m] <= 0;
                beat_cnt[m]  <= '0;
            end
        end else begin
            for (int m = 0; m < 2; m++) begin
                rnd = xorshift32(rnd);
                r1  = rnd;
                rnd = xorshift32(rnd);
                r2  = rnd;
                // AR channel, new read only when the last one finished
                if (mst_ar_valid[m] && mst_ar_ready[m]) begin
                    mst_ar_valid[m] <= 1'b0;
                end else if (!outstanding[m] && issued[m] < NUM_READS && r1[0]) begin
                    req.id    = r1[7:4];
                    req.len   = {1'b0, r1[10:8]};
                    req.size  = AR_SIZE;
                    req.burst = AR_BURST;
                    case (r1[31:16] % 16'd3)
                        16'd0: begin
                            tgt      = TGT_S0;
                            req.addr = {16'h0000, r2[15:2], 2'b00};
                        end
                        16'd1: begin
                            tgt      = TGT_S1;
                            req.addr = {16'h0001, r2[15:2], 2'b00};
                        end
                        default: begin
                            // Upper half of 2 or more lies outside both regions
                            tgt      = TGT_DEF;
                            req.addr = {r2[31:16] | 16'h0002, r2[15:2], 2'b00};
                        end
                    endcase
                    mst_ar[m]       <= req;
                    mst_ar_valid[m] <= 1'b1;
                    outstanding[m]  <= 1'b1;
                    issued[m]       <= issued[m] + 1;
                    exp_id[m]       <= req.id;
                    exp_addr[m]     <= req.addr;
                    exp_len[m]      <= req.len;
                    exp_tgt[m]      <= tgt;
                    beat_cnt[m]     <= '0;
                end
                // R channel
                if (mst_r_valid[m] && mst_r_ready[m]) begin
                    a_expected: assert (outstanding[m]) else begin
                        err_stray++;
                        $display("Master %0d received a read beat at %0t with no read outstanding",
                                 m, $time);
                    end
                    if (outstanding[m]) begin
                        check_beat(m, mst_r[m]);
                        if (beat_cnt[m] == exp_len[m]) begin
                            outstanding[m] <= 1'b0;
                            completed[m]   <= completed[m] + 1;
                        end else begin
                            beat_cnt[m] <= beat_cnt[m] + 4'd1;
                        end
                    end
                end
                mst_r_ready[m] <= r1[1] | r1[2];
            end
        end
    end

    // ============================================================
    // Reset, run and verdict
    // ============================================================
    initial begin
        repeat (3) @(posedge ACLK);
        ARESETn <= 1'b1;
        while (!all_done && cycles < MAX_CYCLES) begin
            @(posedge ACLK);
        end
        if (!all_done) begin
            $display("Timeout after %0d cycles, master 0 finished %0d and master 1 %0d of %0d reads",
                     cycles, completed[0], completed[1], NUM_READS);
        end
        $display("Errors: id %0d, data %0d, resp %0d, last %0d, stray %0d, ar %0d",
                 err_id, err_data, err_resp, err_last, err_stray, err_ar);
        if (all_done &&
            (err_id + err_data + err_resp + err_last + err_stray + err_ar) == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: tests/tb_slave_model.sv
// Behavioural AXI read slave for the testbench
// Serves one burst at a time with random ready and valid gaps.
// Beat k returns (addr + 4k) ^ KEY with an OKAY response

`timescale 1ns/1ps

module tb_slave_model #(
    parameter logic [31:0] KEY  = 32'h0000_0000,
    parameter logic [31:0] SEED = 32'h0000_0001
) (
    input  logic                ACLK,
    input  logic                ARESETn,
    input  axi_rd_pkg::ar_slv_t ar,
    input  logic                ar_valid,
    output logic                ar_ready,
    output axi_rd_pkg::r_slv_t  r,
    output logic                r_valid,
    input  logic                r_ready
);

    logic [31:0]         rnd_q      = SEED;
    logic                ar_ready_q = 1'b0;
    logic                r_valid_q  = 1'b0;
    logic                busy_q     = 1'b0;
    axi_rd_pkg::slv_id_t id_q       = '0;
    logic [31:0]         addr_q     = '0;
    logic [3:0]          len_q      = '0;
    logic [3:0]          cnt_q      = '0;

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    assign ar_ready = ar_ready_q;
    assign r_valid  = r_valid_q;

    // Beat payload follows the beat counter
    always_comb begin
        r      = '0;
        r.id   = id_q;
        r.data = (addr_q + {26'd0, cnt_q, 2'b00}) ^ KEY;
        r.resp = 2'b00;
        r.last = (cnt_q == len_q);
    end

    always @(posedge ACLK or negedge ARESETn) begin
        if (!ARESETn) begin
            rnd_q      <= SEED;
            ar_ready_q <= 1'b0;
            r_valid_q  <= 1'b0;
            busy_q     <= 1'b0;
            cnt_q      <= '0;
        end else begin
            rnd_q <= xorshift32(rnd_q);
            if (!busy_q) begin
                if (ar_valid && ar_ready_q) begin
                    // Take the request, first beat may come next cycle
                    busy_q     <= 1'b1;
                    ar_ready_q <= 1'b0;
                    id_q       <= ar.id;
                    addr_q     <= ar.addr;
                    len_q      <= ar.len;
                    cnt_q      <= '0;
                    r_valid_q  <= rnd_q[2] | rnd_q[3];
                end else begin
                    ar_ready_q <= rnd_q[0] | rnd_q[1];
                end
            end else if (r_valid_q && r_ready) begin
                if (cnt_q == len_q) begin
                    busy_q    <= 1'b0;
                    r_valid_q <= 1'b0;
                end else begin
                    cnt_q     <= cnt_q + 4'd1;
                    r_valid_q <= rnd_q[2] | rnd_q[3];
                end
            end else if (!r_valid_q) begin
                // Gap before the next beat
                r_valid_q <= rnd_q[2] | rnd_q[3];
            end
        end
    end

endmodule
